// File: all.f
logic/rp_pkg.sv
logic/bus_decoder.sv
logic/housekeeping.sv
logic/signal_regs.sv
logic/adc_frontend.sv
logic/dac_formatter.sv
logic/rp_top.sv
sim/tb_clk_gen.sv
sim/tb_rp_top.sv

// File: Bender.yml
package:
  name: rp_top

sources:
  - logic/rp_pkg.sv
  - logic/bus_decoder.sv
  - logic/housekeeping.sv
  - logic/signal_regs.sv
  - logic/adc_frontend.sv
  - logic/dac_formatter.sv
  - logic/rp_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_rp_top.sv

// File: sim/tb_rp_top.sv
`default_nettype none

module tb_rp_top import rp_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          MAX_CYCLES = 3000;  // ~200 bus ops of 4 cycles, plus margin
  localparam int          ACK_WAIT   = 4;     // Edges allowed for an answer
  localparam logic [31:0] LFSR_POLY  = 32'h8020_0003;
  localparam reg_ofs_t    HK_RW_OFS [5] = '{HK_PDIR_OFS, HK_NDIR_OFS, HK_POUT_OFS,
                                            HK_NOUT_OFS, HK_LED_OFS};

  logic      adc_clk, arst_n;
  bus_addr_t sys_addr;
  bus_data_t sys_wdata, sys_rdata;
  logic      sys_wen, sys_ren, sys_err, sys_ack;
  adc_raw_t  adc_dat_a, adc_dat_b;
  dac_code_t dac_a, dac_b;
  led_t      led;
  exp_t      exp_p_in, exp_n_in, exp_p_out, exp_n_out, exp_p_dir, exp_n_dir;

  int          checks = 0;
  int          errors = 0;
  int          chk_base, err_base;  // Counts at test start
  int          cycle_cnt;
  logic [31:0] lfsr = 32'h2f10;

  tb_clk_gen i_clk_gen (.clk_o(adc_clk), .arst_n_o(arst_n));

  rp_top UUT (
    .adc_clk(adc_clk), .arst_n_i(arst_n),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen),
    .sys_ren_i(sys_ren), .sys_rdata_o(sys_rdata), .sys_err_o(sys_err),
    .sys_ack_o(sys_ack), .adc_dat_a_i(adc_dat_a), .adc_dat_b_i(adc_dat_b),
    .dac_dat_a_o(dac_a), .dac_dat_b_o(dac_b), .led_o(led),
    .exp_p_dat_i(exp_p_in), .exp_n_dat_i(exp_n_in),
    .exp_p_dat_o(exp_p_out), .exp_p_dir_o(exp_p_dir),
    .exp_n_dat_o(exp_n_out), .exp_n_dir_o(exp_n_dir)
  );

  //////////////////////////////////////////////////////////////////////////
  // Bus protocol properties
  //////////////////////////////////////////////////////////////////////////

  logic live_sel;     // Address in region 0 or 1
  logic live_strobe;
  assign live_sel    = sys_addr[REGION_MSB:REGION_LSB] < 3'd2;
  assign live_strobe = (sys_wen || sys_ren) && live_sel;

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n)
    live_strobe |=> sys_ack)
    else begin $display("Strobe to a live region got no acknowledge next cycle"); errors++; end
  single_ack: assert property (@(posedge adc_clk) disable iff (!arst_n)
    (sys_ack && live_sel) |-> $past(live_strobe))
    else begin $display("Acknowledge from a live region without a strobe"); errors++; end
  err_needs_ack: assert property (@(posedge adc_clk) disable iff (!arst_n)
    sys_err |-> sys_ack)
    else begin $display("Error raised without acknowledge"); errors++; end
  unused_answer: assert property (@(posedge adc_clk) disable iff (!arst_n)
    !live_sel |-> (sys_ack && sys_rdata == '0 && !sys_err))
    else begin $display("Unused region did not answer with ack and zero data"); errors++; end

  //////////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic bus_addr_t region_addr(input region_t r, input reg_ofs_t ofs);
    return {9'h0, r, ofs};
  endfunction

  // Reference models straight from the converter rules
  function automatic dac_code_t dac_expect(input chan_t v);
    return {v[15], ~v[14:2]};  // Sign, then inverted 14:2
  endfunction

  function automatic bus_data_t adc_expect(input adc_raw_t r);
    logic [13:0] s;
    s = {r[15], ~r[14:2]};
    return {{18{s[13]}}, s};
  endfunction

  function automatic bus_data_t loop_expect(input chan_t v);
    return {{18{v[15]}}, v[15:2]};
  endfunction

  function automatic exp_t hk_port(input int idx);  // Output behind HK_RW_OFS[idx]
    case (idx)
      0:       return exp_p_dir;
      1:       return exp_n_dir;
      2:       return exp_p_out;
      3:       return exp_n_out;
      default: return led;
    endcase
  endfunction

  task automatic check_value(input string name, input bus_data_t exp, input bus_data_t act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // One strobe, then wait for the answer; entered and left 2 ns after an edge
  task automatic bus_access(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                            output bus_data_t rdata, output logic err);
    int waited;
    waited    = 0;
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = ~wr;
    @(posedge adc_clk);
    #2;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    while (!sys_ack && waited < ACK_WAIT)
    begin
      @(posedge adc_clk);
      #2;
      waited++;
    end
    if (!sys_ack)
    begin
      $display("No acknowledge for the access to address %h", addr);
      errors++;
    end
    rdata = sys_rdata;
    err   = sys_err;
    @(posedge adc_clk);  // Idle cycle between operations
    #2;
  endtask

  task automatic write_reg(input string name, input bus_addr_t addr, input bus_data_t data,
                           input logic exp_err);
    bus_data_t rd;
    logic      err;
    bus_access(1'b1, addr, data, rd, err);
    check_value(name, bus_data_t'(exp_err), bus_data_t'(err));
    check_value(name, '0, rd);  // No read data on writes
  endtask

  task automatic read_check(input string name, input bus_addr_t addr, input bus_data_t exp);
    bus_data_t rd;
    logic      err;
    bus_access(1'b0, addr, '0, rd, err);
    check_value(name, '0, bus_data_t'(err));
    check_value(name, exp, rd);
  endtask

  task automatic start_test();
    chk_base = checks;
    err_base = errors;
  endtask

  task automatic end_test(input string name);
    $display("Test %-10s %0d checks, %0d errors", name, checks - chk_base,
             errors - err_base);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////////

  task automatic hk_map_test();
    bus_data_t v;
    start_test();
    read_check("hk_map", region_addr(0, HK_ID_OFS), HK_ID);
    check_value("hk_map", '0, {16'h0, exp_p_dir, exp_n_dir});  // All lanes inputs
    for (int n = 0; n < 4; n++)
    begin
      for (int i = 0; i < 5; i++)
      begin
        v = rand_bits(32);
        write_reg("hk_map", region_addr(0, HK_RW_OFS[i]), v, 1'b0);
        read_check("hk_map", region_addr(0, HK_RW_OFS[i]), {24'h0, v[7:0]});
        check_value("hk_map", {24'h0, v[7:0]}, {24'h0, hk_port(i)});
      end
      exp_p_in = rand_bits(8);  // Live pins
      exp_n_in = rand_bits(8);
      read_check("hk_map", region_addr(0, HK_PIN_OFS), {24'h0, exp_p_in});
      read_check("hk_map", region_addr(0, HK_NIN_OFS), {24'h0, exp_n_in});
    end
    end_test("hk_map");
  endtask

  task automatic bus_error_test();
    bus_data_t rd;
    logic      err;
    start_test();
    write_reg("errors", region_addr(0, HK_ID_OFS), rand_bits(32), 1'b1);
    write_reg("errors", region_addr(0, HK_PIN_OFS), rand_bits(32), 1'b1);
    write_reg("errors", region_addr(0, HK_NIN_OFS), rand_bits(32), 1'b1);
    write_reg("errors", region_addr(1, SR_ADC_A_OFS), rand_bits(32), 1'b1);
    write_reg("errors", region_addr(1, SR_ADC_B_OFS), rand_bits(32), 1'b1);
    write_reg("errors", region_addr(0, 20'h08), rand_bits(32), 1'b1);  // Holes
    write_reg("errors", region_addr(1, 20'h08), rand_bits(32), 1'b1);
    bus_access(1'b0, region_addr(0, 20'h40), '0, rd, err);
    check_value("errors", 32'h1, bus_data_t'(err));
    bus_access(1'b0, region_addr(1, 20'h20), '0, rd, err);
    check_value("errors", 32'h1, bus_data_t'(err));
    read_check("errors", region_addr(0, HK_ID_OFS), HK_ID);  // ID untouched
    end_test("errors");
  endtask

  task automatic unused_region_test();
    start_test();
    for (int r = 2; r < 8; r++)
      read_check("unused", region_addr(region_t'(r), reg_ofs_t'(rand_bits(18) << 2)), '0);
    end_test("unused");
  endtask

  task automatic dac_code_test();
    bus_data_t a, b;
    start_test();
    for (int n = 0; n < 8; n++)
    begin
      a = rand_bits(32);
      b = rand_bits(32);
      write_reg("dac", region_addr(1, SR_DAC_A_OFS), a, 1'b0);
      check_value("dac", bus_data_t'(dac_expect(a[15:0])), bus_data_t'(dac_a));
      write_reg("dac", region_addr(1, SR_DAC_B_OFS), b, 1'b0);
      check_value("dac", bus_data_t'(dac_expect(a[15:0])), bus_data_t'(dac_a));
      check_value("dac", bus_data_t'(dac_expect(b[15:0])), bus_data_t'(dac_b));
      read_check("dac", region_addr(1, SR_DAC_A_OFS), {{16{a[15]}}, a[15:0]});
      read_check("dac", region_addr(1, SR_DAC_B_OFS), {{16{b[15]}}, b[15:0]});
    end
    end_test("dac");
  endtask

  task automatic adc_conv_test();
    start_test();
    for (int n = 0; n < 8; n++)
    begin
      adc_dat_a = rand_bits(16);
      adc_dat_b = rand_bits(16);
      repeat (2) @(posedge adc_clk);  // Held two cycles
      #2;
      read_check("adc", region_addr(1, SR_ADC_A_OFS), adc_expect(adc_dat_a));
      read_check("adc", region_addr(1, SR_ADC_B_OFS), adc_expect(adc_dat_b));
    end
    end_test("adc");
  endtask

  task automatic loopback_test();
    bus_data_t a, b;
    start_test();
    write_reg("loopback", region_addr(0, HK_LOOP_OFS), 32'h1, 1'b0);
    read_check("loopback", region_addr(0, HK_LOOP_OFS), 32'h1);
    for (int n = 0; n < 6; n++)
    begin
      a = rand_bits(32);
      b = rand_bits(32);
      adc_dat_a = rand_bits(16);  // Must be ignored
      adc_dat_b = rand_bits(16);
      write_reg("loopback", region_addr(1, SR_DAC_A_OFS), a, 1'b0);
      write_reg("loopback", region_addr(1, SR_DAC_B_OFS), b, 1'b0);
      read_check("loopback", region_addr(1, SR_ADC_A_OFS), loop_expect(a[15:0]));
      read_check("loopback", region_addr(1, SR_ADC_B_OFS), loop_expect(b[15:0]));
    end
    write_reg("loopback", region_addr(0, HK_LOOP_OFS), 32'h0, 1'b0);
    end_test("loopback");
  endtask

  initial
  begin
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    exp_p_in  = '0;
    exp_n_in  = '0;
    @(posedge arst_n);
    // No edge since release, so this is still the register's reset state
    start_test();
    check_value("reset", 32'h1FFF, bus_data_t'(dac_a));  // Mid-scale, not zero
    check_value("reset", 32'h1FFF, bus_data_t'(dac_b));
    end_test("reset");
    @(posedge adc_clk);
    #2;
    hk_map_test();
    bus_error_test();
    unused_region_test();
    dac_code_test();
    adc_conv_test();
    loopback_test();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;  // 40 ns clock
  localparam int RST_CYCLES  = 4;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release a little after the edge, like the rest of the stimulus
  initial
  begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/rp_top.sv
`default_nettype none

module rp_top import rp_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      arst_n_i,

  // System bus
  input  wire bus_addr_t sys_addr_i,
  input  wire bus_data_t sys_wdata_i,
  input  wire logic      sys_wen_i,
  input  wire logic      sys_ren_i,
  output bus_data_t      sys_rdata_o,
  output logic           sys_err_o,
  output logic           sys_ack_o,

  // Converters
  input  wire adc_raw_t  adc_dat_a_i,
  input  wire adc_raw_t  adc_dat_b_i,
  output dac_code_t      dac_dat_a_o,
  output dac_code_t      dac_dat_b_o,

  // Board IO
  output led_t           led_o,
  input  wire exp_t      exp_p_dat_i,
  input  wire exp_t      exp_n_dat_i,
  output exp_t           exp_p_dat_o,
  output exp_t           exp_p_dir_o,
  output exp_t           exp_n_dat_o,
  output exp_t           exp_n_dir_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  logic      hk_wen, hk_ren;      // Region 0 strobes
  logic      sr_wen, sr_ren;      // Region 1 strobes
  bus_data_t hk_rdata, sr_rdata;
  logic      hk_err, sr_err;
  logic      hk_ack, sr_ack;
  logic      digital_loop;
  chan_t     chan_a, chan_b;      // DAC channel values
  sample_t   sample_a, sample_b;  // Converted ADC data

  // Address split and answer mux
  bus_decoder i_bus_decoder (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_err_i    (hk_err),
    .hk_ack_i    (hk_ack),
    .sr_rdata_i  (sr_rdata),
    .sr_err_i    (sr_err),
    .sr_ack_i    (sr_ack),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .sr_wen_o    (sr_wen),
    .sr_ren_o    (sr_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o)
  );

  // Region 0
  housekeeping i_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .addr_i         (sys_addr_i),
    .wdata_i        (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .exp_p_dat_i    (exp_p_dat_i),
    .exp_n_dat_i    (exp_n_dat_i),
    .rdata_o        (hk_rdata),
    .err_o          (hk_err),
    .ack_o          (hk_ack),
    .led_o          (led_o),
    .digital_loop_o (digital_loop),
    .exp_p_dat_o    (exp_p_dat_o),
    .exp_p_dir_o    (exp_p_dir_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_n_dir_o    (exp_n_dir_o)
  );

  // Region 1
  signal_regs i_sr (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .addr_i     (sys_addr_i),
    .wdata_i    (sys_wdata_i),
    .wen_i      (sr_wen),
    .ren_i      (sr_ren),
    .sample_a_i (sample_a),
    .sample_b_i (sample_b),
    .rdata_o    (sr_rdata),
    .err_o      (sr_err),
    .ack_o      (sr_ack),
    .chan_a_o   (chan_a),
    .chan_b_o   (chan_b)
  );

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .chan_a_i       (chan_a),
    .chan_b_i       (chan_b),
    .sample_a_o     (sample_a),
    .sample_b_o     (sample_b)
  );

  dac_formatter i_dac (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .chan_a_i    (chan_a),
    .chan_b_i    (chan_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// File: logic/dac_formatter.sv
`default_nettype none

module dac_formatter import rp_pkg::*; (
  input  wire logic  adc_clk,
  input  wire logic  arst_n_i,
  input  wire chan_t chan_a_i,
  input  wire chan_t chan_b_i,
  output dac_code_t  dac_dat_a_o,
  output dac_code_t  dac_dat_b_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Sign kept, magnitude bits inverted for the negative slope
  // A zero channel maps to mid-scale 1FFF
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= DAC_ZERO_CODE;  // Mid-scale, not zero
      dac_dat_b_o <= DAC_ZERO_CODE;
    end
    else
    begin
      dac_dat_a_o <= {chan_a_i[15], ~chan_a_i[14:2]};  // Drop 2 LSBs
      dac_dat_b_o <= {chan_b_i[15], ~chan_b_i[14:2]};
    end
  end

endmodule

`default_nettype wire

// File: logic/adc_frontend.sv
`default_nettype none

module adc_frontend import rp_pkg::*; (
  input  wire logic     adc_clk,
  input  wire logic     arst_n_i,
  input  wire adc_raw_t adc_dat_a_i,
  input  wire adc_raw_t adc_dat_b_i,
  input  wire logic     digital_loop_i,
  input  wire chan_t    chan_a_i,
  input  wire chan_t    chan_b_i,
  output sample_t       sample_a_o,
  output sample_t       sample_b_o
);

  logic [13:0] raw_a_q;  // Input register, bits 15:2
  logic [13:0] raw_b_q;
  sample_t     conv_a, conv_b;

  // Capture at the pins, reserved low bits dropped
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      raw_a_q <= adc_dat_a_i[15:2];
      raw_b_q <= adc_dat_b_i[15:2];
    end
  end

  // Negative slope offset binary to two's complement
  assign conv_a = {raw_a_q[13], ~raw_a_q[12:0]};
  assign conv_b = {raw_b_q[13], ~raw_b_q[12:0]};

  // Loopback feeds the DAC values straight back
  assign sample_a_o = digital_loop_i ? chan_a_i[15:2] : conv_a;
  assign sample_b_o = digital_loop_i ? chan_b_i[15:2] : conv_b;

endmodule

`default_nettype wire

// File: logic/signal_regs.sv
`default_nettype none

module signal_regs import rp_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      arst_n_i,
  input  wire bus_addr_t addr_i,
  input  wire bus_data_t wdata_i,
  input  wire logic      wen_i,
  input  wire logic      ren_i,
  input  wire sample_t   sample_a_i,
  input  wire sample_t   sample_b_i,
  output bus_data_t      rdata_o,
  output logic           err_o,
  output logic           ack_o,
  output chan_t          chan_a_o,
  output chan_t          chan_b_o
);

  reg_ofs_t  ofs;
  bus_data_t rd_val;
  logic      rd_ok;
  logic      wr_ok;
  chan_t     chan_a_q, chan_b_q;

  assign ofs = addr_i[REGION_LSB-1:0];

  // Read mux, everything sign-extended to the bus word
  always_comb
  begin
    rd_val = '0;
    rd_ok  = 1'b1;
    wr_ok  = 1'b1;
    case (ofs)
      SR_DAC_A_OFS: rd_val = {{16{chan_a_q[15]}}, chan_a_q};
      SR_DAC_B_OFS: rd_val = {{16{chan_b_q[15]}}, chan_b_q};
      SR_ADC_A_OFS:
      begin
        rd_val = {{18{sample_a_i[13]}}, sample_a_i};
        wr_ok  = 1'b0;  // Samples are read-only
      end
      SR_ADC_B_OFS:
      begin
        rd_val = {{18{sample_b_i[13]}}, sample_b_i};
        wr_ok  = 1'b0;
      end
      default:
      begin
        rd_ok = 1'b0;
        wr_ok = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel registers, low half of the write word
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      chan_a_q <= '0;
      chan_b_q <= '0;
    end
    else if (wen_i)
    begin
      if (ofs == SR_DAC_A_OFS)
        chan_a_q <= wdata_i[15:0];
      if (ofs == SR_DAC_B_OFS)
        chan_b_q <= wdata_i[15:0];
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o   <= wen_i | ren_i;                        // One cycle latency
      err_o   <= (wen_i & ~wr_ok) | (ren_i & ~rd_ok);
      rdata_o <= ren_i ? rd_val : '0;
    end
  end

  assign chan_a_o = chan_a_q;
  assign chan_b_o = chan_b_q;

endmodule

`default_nettype wire

// File: logic/housekeeping.sv
`default_nettype none

module housekeeping import rp_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      arst_n_i,
  input  wire bus_addr_t addr_i,
  input  wire bus_data_t wdata_i,
  input  wire logic      wen_i,
  input  wire logic      ren_i,
  input  wire exp_t      exp_p_dat_i,
  input  wire exp_t      exp_n_dat_i,
  output bus_data_t      rdata_o,
  output logic           err_o,
  output logic           ack_o,
  output led_t           led_o,
  output logic           digital_loop_o,
  output exp_t           exp_p_dat_o,
  output exp_t           exp_p_dir_o,
  output exp_t           exp_n_dat_o,
  output exp_t           exp_n_dir_o
);

  reg_ofs_t  ofs;
  bus_data_t rd_val;   // Read mux result
  logic      rd_ok;    // Offset readable
  logic      wr_ok;    // Offset writable

  logic      loop_q;
  exp_t      pdir_q, ndir_q;  // 1 = lane drives
  exp_t      pout_q, nout_q;
  led_t      led_q;

  assign ofs = addr_i[REGION_LSB-1:0];

  //////////////////////////////////////////////////////////////////////////
  // Register map decode
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_val = '0;
    rd_ok  = 1'b1;
    wr_ok  = 1'b1;
    case (ofs)
      HK_ID_OFS:
      begin
        rd_val = HK_ID;
        wr_ok  = 1'b0;  // Constant
      end
      HK_LOOP_OFS: rd_val = bus_data_t'(loop_q);
      HK_PDIR_OFS: rd_val = bus_data_t'(pdir_q);
      HK_NDIR_OFS: rd_val = bus_data_t'(ndir_q);
      HK_POUT_OFS: rd_val = bus_data_t'(pout_q);
      HK_NOUT_OFS: rd_val = bus_data_t'(nout_q);
      HK_PIN_OFS:
      begin
        rd_val = bus_data_t'(exp_p_dat_i);  // Live pins
        wr_ok  = 1'b0;
      end
      HK_NIN_OFS:
      begin
        rd_val = bus_data_t'(exp_n_dat_i);
        wr_ok  = 1'b0;
      end
      HK_LED_OFS:  rd_val = bus_data_t'(led_q);
      default:
      begin
        rd_ok = 1'b0;  // Hole in the map
        wr_ok = 1'b0;
      end
    endcase
  end

  // Writable registers, all lanes inputs after reset
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q <= 1'b0;
      pdir_q <= '0;
      ndir_q <= '0;
      pout_q <= '0;
      nout_q <= '0;
      led_q  <= '0;
    end
    else if (wen_i)
    begin
      case (ofs)
        HK_LOOP_OFS: loop_q <= wdata_i[0];
        HK_PDIR_OFS: pdir_q <= wdata_i[7:0];
        HK_NDIR_OFS: ndir_q <= wdata_i[7:0];
        HK_POUT_OFS: pout_q <= wdata_i[7:0];
        HK_NOUT_OFS: nout_q <= wdata_i[7:0];
        HK_LED_OFS:  led_q  <= wdata_i[7:0];
        default: ;  // Read-only or unmapped
      endcase
    end
  end

  // Bus answer, one cycle after the strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o   <= wen_i | ren_i;
      err_o   <= (wen_i & ~wr_ok) | (ren_i & ~rd_ok);
      rdata_o <= ren_i ? rd_val : '0;  // Zero on writes
    end
  end

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;
  assign exp_p_dir_o    = pdir_q;
  assign exp_n_dir_o    = ndir_q;
  assign exp_p_dat_o    = pout_q;
  assign exp_n_dat_o    = nout_q;

endmodule

`default_nettype wire

// File: logic/bus_decoder.sv
`default_nettype none

module bus_decoder import rp_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      arst_n_i,
  input  wire bus_addr_t sys_addr_i,
  input  wire logic      sys_wen_i,
  input  wire logic      sys_ren_i,
  input  wire bus_data_t hk_rdata_i,
  input  wire logic      hk_err_i,
  input  wire logic      hk_ack_i,
  input  wire bus_data_t sr_rdata_i,
  input  wire logic      sr_err_i,
  input  wire logic      sr_ack_i,
  output logic           hk_wen_o,
  output logic           hk_ren_o,
  output logic           sr_wen_o,
  output logic           sr_ren_o,
  output bus_data_t      sys_rdata_o,
  output logic           sys_err_o,
  output logic           sys_ack_o
);

  region_t        region;    // Region of current address
  region_onehot_t sel;       // One-hot chip select
  region_t        region_q;  // Region of last strobe
  logic           hk_resp;   // Region 0 answering now
  logic           sr_resp;   // Region 1 answering now
  logic           unused_sel;

  assign region     = sys_addr_i[REGION_MSB:REGION_LSB];
  assign sel        = region_onehot_t'(1) << region;
  assign unused_sel = |sel[NUM_REGIONS-1:2];  // Regions 2..7

  // Strobe fan-out to the live slaves
  assign hk_wen_o = sel[0] & sys_wen_i;
  assign hk_ren_o = sel[0] & sys_ren_i;
  assign sr_wen_o = sel[1] & sys_wen_i;
  assign sr_ren_o = sel[1] & sys_ren_i;

  // Answer comes a cycle late, so remember who was asked
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      region_q <= '0;
    else if (sys_wen_i || sys_ren_i)
      region_q <= region;
  end

  assign hk_resp = (region_q == 3'd0) && hk_ack_i;
  assign sr_resp = (region_q == 3'd1) && sr_ack_i;

  assign sys_ack_o   = hk_resp | sr_resp | unused_sel;  // Unused slaves always ready
  assign sys_err_o   = (hk_resp & hk_err_i) | (sr_resp & sr_err_i);
  assign sys_rdata_o = hk_resp ? hk_rdata_i :
                       sr_resp ? sr_rdata_i : '0;  // Unused read as zero

endmodule

`default_nettype wire

// File: logic/rp_pkg.sv
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // System bus geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_REGIONS = 8;   // Address space split
  localparam int REGION_LSB  = 20;  // Lowest region select bit
  localparam int REGION_MSB  = 22;  // Highest region select bit

  typedef logic [31:0]              bus_addr_t;
  typedef logic [31:0]              bus_data_t;
  typedef logic [2:0]               region_t;
  typedef logic [NUM_REGIONS-1:0]   region_onehot_t;
  typedef logic [REGION_LSB-1:0]    reg_ofs_t;   // Offset inside one region

  ////////////////////////////////////////////////////////////////////////////
  // Converter and board widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic        [15:0] adc_raw_t;   // Bits 1:0 reserved
  typedef logic signed [13:0] sample_t;    // Two's complement sample
  typedef logic        [13:0] dac_code_t;  // Negative slope offset code
  typedef logic signed [15:0] chan_t;      // Channel value, signed
  typedef logic        [7:0]  exp_t;       // Expansion lane group
  typedef logic        [7:0]  led_t;

  // Code of a zero channel value, also the DAC register reset state
  localparam dac_code_t DAC_ZERO_CODE = 14'h1FFF;

  // Region 0 map
  localparam bus_data_t HK_ID       = 32'h5250_0001;
  localparam reg_ofs_t  HK_ID_OFS   = 20'h00;
  localparam reg_ofs_t  HK_LOOP_OFS = 20'h04;  // Bit 0 only
  localparam reg_ofs_t  HK_PDIR_OFS = 20'h10;
  localparam reg_ofs_t  HK_NDIR_OFS = 20'h14;
  localparam reg_ofs_t  HK_POUT_OFS = 20'h18;
  localparam reg_ofs_t  HK_NOUT_OFS = 20'h1C;
  localparam reg_ofs_t  HK_PIN_OFS  = 20'h20;
  localparam reg_ofs_t  HK_NIN_OFS  = 20'h24;
  localparam reg_ofs_t  HK_LED_OFS  = 20'h30;

  // Region 1 map
  localparam reg_ofs_t  SR_DAC_A_OFS = 20'h00;
  localparam reg_ofs_t  SR_DAC_B_OFS = 20'h04;
  localparam reg_ofs_t  SR_ADC_A_OFS = 20'h10;
  localparam reg_ofs_t  SR_ADC_B_OFS = 20'h14;

endpackage

`default_nettype wire
